/* include/immu_params.svh */
////////////////////
// Instruction MMU parameters
// Address and data widths, page geometry, TLB size and exception vectors
////////////////////

`ifndef IMMU_PARAMS_SVH
`define IMMU_PARAMS_SVH

// Address and data width
`define NCPU_AW 32
`define NCPU_DW 32

// Page offset bits, 8 KiB pages
`define PAGE_SHIFT 13
// Virtual and physical page number width
`define VPN_DW 19

// TLB index width, 16 entries
`define ITLB_AW 4

// Exception vectors for TLB miss and page fault
`define EITM_VECTOR 32'h0000_0100
`define EIPF_VECTOR 32'h0000_0200

`endif

/* verilog/immu_pkg.sv */
////////////////////
// Instruction MMU types
// Virtual address views, TLB word layouts and the exception code
////////////////////

`include "immu_params.svh"

package immu_pkg;

   // Page view of a virtual address
   typedef struct packed {
      logic [`VPN_DW-1:0]     vpn;
      logic [`PAGE_SHIFT-1:0] offset;
   } vpage_t;

   // Same word read flat or as page number plus offset
   typedef union packed {
      logic [`NCPU_AW-1:0] raw;
      vpage_t              pg;
   } vaddr_u;

   // TLB low word, tag and valid
   typedef struct packed {
      logic [`VPN_DW-1:0] vpn;
      logic [11:0]        rsv;
      logic               v;
   } tlbl_t;

   // TLB high word, frame number and attributes
   typedef struct packed {
      logic [`VPN_DW-1:0] ppn;
      logic [3:0]         rsv_a;
      logic               s;
      logic [2:0]         rsv_b;
      logic               rx;
      logic               ux;
      logic [1:0]         rsv_c;
      logic               p;
   } tlbh_t;

   // Fetch exception code
   typedef struct packed {
      logic pf;
      logic itm;
   } exc_t;

endpackage

/* verilog/fetch_pipebuf.sv */
////////////////////
// One-entry stage control
// Valid/ready occupancy flag with flush, gives the stage clock enable
////////////////////

module fetch_pipebuf (
   input  logic clk,
   input  logic rst,
   input  logic flush,
   input  logic a_valid,
   output logic a_ready,
   output logic b_valid,
   input  logic b_ready,
   output logic cke
);

   logic full;

   // Room when empty or when the held item leaves this cycle
   assign a_ready = ~full | b_ready;
   assign b_valid = full;

   // Load strobe for the stage registers
   // No load while a flush is squashing the input
   assign cke = a_valid & a_ready & ~flush;

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (flush) begin
         full <= 1'b0;
      end else if (a_ready) begin
         full <= a_valid;
      end
   end

endmodule

/* verilog/tlb_ram.sv */
////////////////////
// TLB storage
// Dual-port synchronous RAM, lookup port A and software port B
// Port B writes bypass to a same-address read on port A
////////////////////

`include "immu_params.svh"

module tlb_ram (
   input  logic                clk,
   input  logic                rst,
   input  logic [`ITLB_AW-1:0] addr_a,
   input  logic                en_a,
   output logic [`NCPU_DW-1:0] dout_a,
   input  logic [`ITLB_AW-1:0] addr_b,
   input  logic                we_b,
   input  logic [`NCPU_DW-1:0] din_b,
   output logic [`NCPU_DW-1:0] dout_b
);

   localparam int DEPTH = 1 << `ITLB_AW;

   logic [`NCPU_DW-1:0] mem [DEPTH];

   // Software write
   always_ff @(posedge clk) begin
      if (we_b) begin
         mem[addr_b] <= din_b;
      end
   end

   // Lookup read, output held while en_a is low
   always_ff @(posedge clk) begin
      if (rst) begin
         dout_a <= '0;
      end else if (en_a) begin
         // Same-cycle write wins over the stale entry
         if (we_b && (addr_b == addr_a)) begin
            dout_a <= din_b;
         end else begin
            dout_a <= mem[addr_a];
         end
      end
   end

   // Readback, write-first
   always_ff @(posedge clk) begin
      if (rst) begin
         dout_b <= '0;
      end else if (we_b) begin
         dout_b <= din_b;
      end else begin
         dout_b <= mem[addr_b];
      end
   end

endmodule

/* verilog/fetch_seq.sv */
////////////////////
// Fetch sequencer
// Holds the fetch PC and issues word addresses to the MMU
////////////////////

`include "immu_params.svh"

module fetch_seq (
   input  logic             clk,
   input  logic             rst,
   input  logic             start,
   input  immu_pkg::vaddr_u start_addr,
   input  logic             run,
   input  logic             redirect,
   input  immu_pkg::vaddr_u redirect_addr,
   output logic             f_valid,
   input  logic             f_ready,
   output immu_pkg::vaddr_u f_addr
);

   // f_addr is the PC itself
   always_ff @(posedge clk) begin
      if (rst) begin
         f_addr.raw <= '0;
         f_valid    <= 1'b0;
      end else if (start) begin
         // New program start, drop any pending issue
         f_addr  <= start_addr;
         f_valid <= 1'b0;
      end else if (redirect) begin
         // Exception redirect squashes the unaccepted address
         f_addr  <= redirect_addr;
         f_valid <= 1'b0;
      end else begin
         // Step one word per accepted transfer
         if (f_valid && f_ready) begin
            f_addr.raw <= f_addr.raw + `NCPU_AW'(4);
         end
         // Keep an unaccepted request up even when run drops
         f_valid <= run | (f_valid & ~f_ready);
      end
   end

endmodule

/* verilog/immu.sv */
////////////////////
// Instruction MMU
// Direct-mapped TLB lookup, miss and permission checks
// Exceptions replace the address with their vector
////////////////////

`include "immu_params.svh"

module immu (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,
   input  logic                f_valid,
   output logic                f_ready,
   input  immu_pkg::vaddr_u    f_addr,
   output logic                m_valid,
   input  logic                m_ready,
   output immu_pkg::vaddr_u    m_addr,
   output immu_pkg::exc_t      m_exc,
   input  logic                imme,
   input  logic                rm,
   output logic [`NCPU_DW-1:0] immid,
   output logic [`NCPU_DW-1:0] tlbl,
   input  logic [`ITLB_AW-1:0] tlbl_idx,
   input  logic [`NCPU_DW-1:0] tlbl_nxt,
   input  logic                tlbl_we,
   output logic [`NCPU_DW-1:0] tlbh,
   input  logic [`ITLB_AW-1:0] tlbh_idx,
   input  logic [`NCPU_DW-1:0] tlbh_nxt,
   input  logic                tlbh_we
);
   import immu_pkg::*;

   logic                   cke;
   logic                   imme_r;
   logic                   rm_r;
   logic [`VPN_DW-1:0]     vpn_r;
   logic [`PAGE_SHIFT-1:0] offset_r;
   logic [`NCPU_AW-1:0]    raw_r;
   tlbl_t                  tlb_l;
   tlbh_t                  tlb_h;
   logic                   tlb_miss;
   logic                   perm_denied;

   fetch_pipebuf u_pipebuf (
      .clk     (clk),
      .rst     (rst),
      .flush   (flush),
      .a_valid (f_valid),
      .a_ready (f_ready),
      .b_valid (m_valid),
      .b_ready (m_ready),
      .cke     (cke)
   );

   // TLB size report
   assign immid = `NCPU_DW'(`ITLB_AW);

   // Request fields, captured with the RAM read
   always_ff @(posedge clk) begin
      if (cke) begin
         imme_r   <= imme;
         rm_r     <= rm;
         vpn_r    <= f_addr.pg.vpn;
         offset_r <= f_addr.pg.offset;
         raw_r    <= f_addr.raw;
      end
   end

   // Low word, tag and valid
   tlb_ram u_tlb_l (
      .clk    (clk),
      .rst    (rst),
      .addr_a (f_addr.pg.vpn[`ITLB_AW-1:0]),
      .en_a   (cke),
      .dout_a (tlb_l),
      .addr_b (tlbl_idx),
      .we_b   (tlbl_we),
      .din_b  (tlbl_nxt),
      .dout_b (tlbl)
   );

   // High word, frame and permissions
   tlb_ram u_tlb_h (
      .clk    (clk),
      .rst    (rst),
      .addr_a (f_addr.pg.vpn[`ITLB_AW-1:0]),
      .en_a   (cke),
      .dout_a (tlb_h),
      .addr_b (tlbh_idx),
      .we_b   (tlbh_we),
      .din_b  (tlbh_nxt),
      .dout_b (tlbh)
   );

   // Miss on invalid entry or tag mismatch
   assign tlb_miss = ~tlb_l.v | (tlb_l.vpn != vpn_r);
   // Root mode checks rx, user mode checks ux
   assign perm_denied = rm_r ? ~tlb_h.rx : ~tlb_h.ux;

   // Page fault only on a hit, both only with translation on
   assign m_exc.itm = imme_r & tlb_miss;
   assign m_exc.pf  = imme_r & ~tlb_miss & perm_denied;

   always_comb begin
      if (!imme_r) begin
         m_addr.raw = raw_r;
      end else if (m_exc.itm) begin
         m_addr.raw = `EITM_VECTOR;
      end else if (m_exc.pf) begin
         m_addr.raw = `EIPF_VECTOR;
      end else begin
         // Frame number joined with the page offset
         m_addr.pg.vpn    = tlb_h.ppn;
         m_addr.pg.offset = offset_r;
      end
   end

endmodule

/* verilog/fetch_commit.sv */
////////////////////
// Fetch commit stage
// Output register, redirects the sequencer on an exception
////////////////////

module fetch_commit (
   input  logic             clk,
   input  logic             rst,
   input  logic             m_valid,
   output logic             m_ready,
   input  immu_pkg::vaddr_u m_addr,
   input  immu_pkg::exc_t   m_exc,
   output logic             out_valid,
   input  logic             out_ready,
   output immu_pkg::vaddr_u out_addr,
   output immu_pkg::exc_t   out_exc,
   output logic             redirect,
   output immu_pkg::vaddr_u redirect_addr
);

   // Free when empty or when the output is taken
   assign m_ready = ~out_valid | out_ready;

   // Exception leaves the output, pulse once
   assign redirect = out_valid & out_ready & (out_exc.itm | out_exc.pf);
   // Vector already sits in the address
   assign redirect_addr = out_addr;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (m_ready) begin
         // Item arriving behind an exception is squashed
         out_valid <= m_valid & ~redirect;
      end
   end

   // Result payload
   always_ff @(posedge clk) begin
      if (m_valid && m_ready) begin
         out_addr <= m_addr;
         out_exc  <= m_exc;
      end
   end

endmodule

/* verilog/immu_top.sv */
////////////////////
// Instruction fetch address path
// Sequencer, MMU and commit stage in a row
////////////////////

`include "immu_params.svh"

module immu_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,
   input  immu_pkg::vaddr_u    start_addr,
   input  logic                run,
   input  logic                imme,
   input  logic                rm,
   output logic [`NCPU_DW-1:0] immid,
   output logic [`NCPU_DW-1:0] tlbl,
   input  logic [`ITLB_AW-1:0] tlbl_idx,
   input  logic [`NCPU_DW-1:0] tlbl_nxt,
   input  logic                tlbl_we,
   output logic [`NCPU_DW-1:0] tlbh,
   input  logic [`ITLB_AW-1:0] tlbh_idx,
   input  logic [`NCPU_DW-1:0] tlbh_nxt,
   input  logic                tlbh_we,
   output logic                out_valid,
   input  logic                out_ready,
   output immu_pkg::vaddr_u    out_addr,
   output immu_pkg::exc_t      out_exc
);
   import immu_pkg::*;

   logic   f_valid;
   logic   f_ready;
   vaddr_u f_addr;
   logic   m_valid;
   logic   m_ready;
   vaddr_u m_addr;
   exc_t   m_exc;
   logic   redirect;
   vaddr_u redirect_addr;

   fetch_seq u_seq (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .start_addr    (start_addr),
      .run           (run),
      .redirect      (redirect),
      .redirect_addr (redirect_addr),
      .f_valid       (f_valid),
      .f_ready       (f_ready),
      .f_addr        (f_addr)
   );

   // Redirect also flushes the MMU entry
   immu u_immu (
      .clk      (clk),
      .rst      (rst),
      .flush    (redirect),
      .f_valid  (f_valid),
      .f_ready  (f_ready),
      .f_addr   (f_addr),
      .m_valid  (m_valid),
      .m_ready  (m_ready),
      .m_addr   (m_addr),
      .m_exc    (m_exc),
      .imme     (imme),
      .rm       (rm),
      .immid    (immid),
      .tlbl     (tlbl),
      .tlbl_idx (tlbl_idx),
      .tlbl_nxt (tlbl_nxt),
      .tlbl_we  (tlbl_we),
      .tlbh     (tlbh),
      .tlbh_idx (tlbh_idx),
      .tlbh_nxt (tlbh_nxt),
      .tlbh_we  (tlbh_we)
   );

   fetch_commit u_commit (
      .clk           (clk),
      .rst           (rst),
      .m_valid       (m_valid),
      .m_ready       (m_ready),
      .m_addr        (m_addr),
      .m_exc         (m_exc),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_addr      (out_addr),
      .out_exc       (out_exc),
      .redirect      (redirect),
      .redirect_addr (redirect_addr)
   );

endmodule

/* tests/immu_tb.sv */
////////////////////
// Fetch address path testbench
// Table-driven rows checked against a translation model
////////////////////

`include "immu_params.svh"

module immu_tb;
   import immu_pkg::*;

   localparam int NROWS   = 8;
   localparam int MAXE    = 3;
   localparam int ENTRIES = 1 << `ITLB_AW;

   logic                clk;
   logic                rst;
   logic                start;
   vaddr_u              start_addr;
   logic                run;
   logic                imme;
   logic                rm;
   logic [`NCPU_DW-1:0] immid;
   logic [`NCPU_DW-1:0] tlbl;
   logic [`ITLB_AW-1:0] tlbl_idx;
   logic [`NCPU_DW-1:0] tlbl_nxt;
   logic                tlbl_we;
   logic [`NCPU_DW-1:0] tlbh;
   logic [`ITLB_AW-1:0] tlbh_idx;
   logic [`NCPU_DW-1:0] tlbh_nxt;
   logic                tlbh_we;
   logic                out_valid;
   logic                out_ready;
   vaddr_u              out_addr;
   exc_t                out_exc;

   // Stimulus table with one row per scenario
   logic                row_imme  [NROWS];
   logic                row_rm    [NROWS];
   logic                row_rand  [NROWS];
   logic [`NCPU_AW-1:0] row_start [NROWS];
   int                  row_nout  [NROWS];
   int                  row_nent  [NROWS];
   logic [`ITLB_AW-1:0] ent_idx   [NROWS][MAXE];
   logic [`NCPU_DW-1:0] ent_lo    [NROWS][MAXE];
   logic [`NCPU_DW-1:0] ent_hi    [NROWS][MAXE];

   // Model copy of the TLB contents
   tlbl_t ref_lo [ENTRIES];
   tlbh_t ref_hi [ENTRIES];

   logic [31:0] rng_state;
   int          cycles = 0;
   int          cycle_limit = 0;

   immu_top dut0 (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .start_addr (start_addr),
      .run        (run),
      .imme       (imme),
      .rm         (rm),
      .immid      (immid),
      .tlbl       (tlbl),
      .tlbl_idx   (tlbl_idx),
      .tlbl_nxt   (tlbl_nxt),
      .tlbl_we    (tlbl_we),
      .tlbh       (tlbh),
      .tlbh_idx   (tlbh_idx),
      .tlbh_nxt   (tlbh_nxt),
      .tlbh_we    (tlbh_we),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_addr   (out_addr),
      .out_exc    (out_exc)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   // Run length guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         fail_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
      end
   end

   task automatic check_addr(input string name, input vaddr_u got, input vaddr_u exp);
      if (got.raw !== exp.raw) begin
         fail_run($sformatf("error at %0t: %s got %h expected %h",
                            $time, name, got.raw, exp.raw));
      end
   endtask

   task automatic check_exc(input string name, input exc_t got, input exc_t exp);
      if (got !== exp) begin
         fail_run($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_word(input string name, input logic [`NCPU_DW-1:0] got,
                             input logic [`NCPU_DW-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Low word from tag and valid
   function automatic logic [`NCPU_DW-1:0] lo_word(input logic [`VPN_DW-1:0] vpn,
                                                   input logic v);
      tlbl_t w;
      w     = '0;
      w.vpn = vpn;
      w.v   = v;
      return w;
   endfunction

   // High word from frame and execute bits
   function automatic logic [`NCPU_DW-1:0] hi_word(input logic [`VPN_DW-1:0] ppn,
                                                   input logic rx, input logic ux);
      tlbh_t w;
      w     = '0;
      w.ppn = ppn;
      w.rx  = rx;
      w.ux  = ux;
      return w;
   endfunction

   task automatic set_row(input int r, input logic im, input logic root,
                          input logic [`NCPU_AW-1:0] sa, input int n, input logic rnd);
      row_imme[r]  = im;
      row_rm[r]    = root;
      row_start[r] = sa;
      row_nout[r]  = n;
      row_rand[r]  = rnd;
      row_nent[r]  = 0;
   endtask

   task automatic add_entry(input int r, input logic [`ITLB_AW-1:0] idx,
                            input logic [`NCPU_DW-1:0] lo, input logic [`NCPU_DW-1:0] hi);
      int k;
      k            = row_nent[r];
      ent_idx[r][k] = idx;
      ent_lo[r][k]  = lo;
      ent_hi[r][k]  = hi;
      row_nent[r]  = k + 1;
   endtask

   // Same scenario under the other ready mode
   task automatic copy_row(input int dst, input int src, input logic rnd);
      set_row(dst, row_imme[src], row_rm[src], row_start[src], row_nout[src], rnd);
      for (int k = 0; k < row_nent[src]; k++) begin
         add_entry(dst, ent_idx[src][k], ent_lo[src][k], ent_hi[src][k]);
      end
   endtask

   task automatic load_table();
      // Translation off gives plain sequential addresses
      set_row(0, 1'b0, 1'b0, 32'h0000_1000, 6, 1'b0);
      // User mode walk from page 1 into page 2
      set_row(1, 1'b1, 1'b0, 32'h0000_3ff4, 6, 1'b0);
      add_entry(1, 4'd1, lo_word(19'h1, 1'b1), hi_word(19'h41, 1'b1, 1'b1));
      add_entry(1, 4'd2, lo_word(19'h2, 1'b1), hi_word(19'h52, 1'b1, 1'b1));
      // Root mode with another tag in the page 4 slot
      set_row(2, 1'b1, 1'b1, 32'h0000_7ff8, 7, 1'b0);
      add_entry(2, 4'd0, lo_word(19'h0, 1'b1), hi_word(19'h7, 1'b1, 1'b1));
      add_entry(2, 4'd3, lo_word(19'h3, 1'b1), hi_word(19'h33, 1'b1, 1'b1));
      add_entry(2, 4'd4, lo_word(19'h14, 1'b1), hi_word(19'h44, 1'b1, 1'b1));
      // Right tag but entry not valid
      set_row(3, 1'b1, 1'b0, 32'h0000_a000, 5, 1'b0);
      add_entry(3, 4'd0, lo_word(19'h0, 1'b1), hi_word(19'h7, 1'b1, 1'b1));
      add_entry(3, 4'd5, lo_word(19'h5, 1'b0), hi_word(19'h55, 1'b1, 1'b1));
      // User fetch from a page without ux
      set_row(4, 1'b1, 1'b0, 32'h0000_c000, 5, 1'b0);
      add_entry(4, 4'd0, lo_word(19'h0, 1'b1), hi_word(19'h7, 1'b1, 1'b1));
      add_entry(4, 4'd6, lo_word(19'h6, 1'b1), hi_word(19'h66, 1'b1, 1'b0));
      // Root mode where page 6 has rx and page 7 lacks it
      set_row(5, 1'b1, 1'b1, 32'h0000_dff8, 6, 1'b0);
      add_entry(5, 4'd0, lo_word(19'h0, 1'b1), hi_word(19'h7, 1'b1, 1'b1));
      add_entry(5, 4'd6, lo_word(19'h6, 1'b1), hi_word(19'h66, 1'b1, 1'b0));
      add_entry(5, 4'd7, lo_word(19'h7, 1'b1), hi_word(19'h77, 1'b0, 1'b1));
      // Back-pressure versions of the exception rows
      copy_row(6, 2, 1'b1);
      copy_row(7, 5, 1'b1);
   endtask

   // Invalidate every entry one per cycle
   task automatic clear_tlb();
      for (int i = 0; i < ENTRIES; i++) begin
         @(negedge clk);
         tlbl_idx  = `ITLB_AW'(i);
         tlbl_nxt  = '0;
         tlbl_we   = 1'b1;
         tlbh_idx  = `ITLB_AW'(i);
         tlbh_nxt  = '0;
         tlbh_we   = 1'b1;
         ref_lo[i] = '0;
         ref_hi[i] = '0;
      end
      @(negedge clk);
      tlbl_we = 1'b0;
      tlbh_we = 1'b0;
   endtask

   task automatic write_tlb(input logic [`ITLB_AW-1:0] idx,
                            input logic [`NCPU_DW-1:0] lo, input logic [`NCPU_DW-1:0] hi);
      @(negedge clk);
      tlbl_idx = idx;
      tlbl_nxt = lo;
      tlbl_we  = 1'b1;
      tlbh_idx = idx;
      tlbh_nxt = hi;
      tlbh_we  = 1'b1;
      @(negedge clk);
      tlbl_we     = 1'b0;
      tlbh_we     = 1'b0;
      ref_lo[idx] = lo;
      ref_hi[idx] = hi;
      // Plain read of the stored words
      @(negedge clk);
      check_word("tlbl", tlbl, lo);
      check_word("tlbh", tlbh, hi);
   endtask

   // Model of one fetch giving result and following PC
   task automatic expect_fetch(input vaddr_u pc, input logic im, input logic root,
                               output vaddr_u addr, output exc_t exc, output vaddr_u next_pc);
      logic [`ITLB_AW-1:0] idx;
      tlbl_t               l;
      tlbh_t               h;
      addr = pc;
      exc  = '0;
      if (im) begin
         idx = pc.pg.vpn[`ITLB_AW-1:0];
         l   = ref_lo[idx];
         h   = ref_hi[idx];
         if (!l.v || (l.vpn != pc.pg.vpn)) begin
            exc.itm  = 1'b1;
            addr.raw = `EITM_VECTOR;
         end else if (root ? !h.rx : !h.ux) begin
            exc.pf   = 1'b1;
            addr.raw = `EIPF_VECTOR;
         end else begin
            addr.pg.vpn    = h.ppn;
            addr.pg.offset = pc.pg.offset;
         end
      end
      // Exceptions restart at their vector
      if (exc.itm || exc.pf) begin
         next_pc = addr;
      end else begin
         next_pc.raw = pc.raw + `NCPU_AW'(4);
      end
   endtask

   task automatic pulse_reset();
      @(negedge clk);
      rst = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic run_row(input int r);
      vaddr_u pc;
      vaddr_u exp_addr;
      vaddr_u next_pc;
      exc_t   exp_exc;
      logic   rdy;
      int     got;
      int     idle;
      clear_tlb();
      for (int k = 0; k < row_nent[r]; k++) begin
         write_tlb(ent_idx[r][k], ent_lo[r][k], ent_hi[r][k]);
      end
      @(negedge clk);
      imme           = row_imme[r];
      rm             = row_rm[r];
      start_addr.raw = row_start[r];
      start          = 1'b1;
      @(negedge clk);
      start  = 1'b0;
      run    = 1'b1;
      pc.raw = row_start[r];
      got    = 0;
      while (got < row_nout[r]) begin
         @(negedge clk);
         if (row_rand[r]) begin
            rng_state = xorshift32(rng_state);
            rdy       = rng_state[0];
         end else begin
            rdy = 1'b1;
         end
         out_ready = rdy;
         // Transfer at the coming rising edge
         if (out_valid === 1'b1 && rdy) begin
            expect_fetch(pc, row_imme[r], row_rm[r], exp_addr, exp_exc, next_pc);
            check_addr("out_addr", out_addr, exp_addr);
            check_exc("out_exc", out_exc, exp_exc);
            pc  = next_pc;
            got = got + 1;
         end
      end
      // Drain what is still in flight
      @(negedge clk);
      run       = 1'b0;
      out_ready = 1'b1;
      idle      = 0;
      while (idle < 4) begin
         @(negedge clk);
         if (out_valid) begin
            idle = 0;
         end else begin
            idle = idle + 1;
         end
      end
      pulse_reset();
   endtask

   initial begin
      rst            = 1'b1;
      start          = 1'b0;
      start_addr.raw = '0;
      run            = 1'b0;
      imme           = 1'b0;
      rm             = 1'b0;
      tlbl_idx       = '0;
      tlbl_nxt       = '0;
      tlbl_we        = 1'b0;
      tlbh_idx       = '0;
      tlbh_nxt       = '0;
      tlbh_we        = 1'b0;
      out_ready      = 1'b0;
      rng_state      = 32'h2e92_9ae4;
      load_table();
      cycle_limit = 200;
      for (int r = 0; r < NROWS; r++) begin
         cycle_limit = cycle_limit + row_nout[r] * 20;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Index width that addresses every model entry
      check_word("immid", immid, `NCPU_DW'($clog2(ENTRIES)));
      for (int r = 0; r < NROWS; r++) begin
         run_row(r);
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* build.f */
+incdir+include
verilog/immu_pkg.sv
verilog/fetch_pipebuf.sv
verilog/tlb_ram.sv
verilog/fetch_seq.sv
verilog/immu.sv
verilog/fetch_commit.sv
verilog/immu_top.sv
tests/immu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the fetch path testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module immu_tb \
   --Mdir obj_dir -o immu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/immu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit 1
fi

exit 0
